// ==== logic/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // line geometry
    localparam int line_words = 4;   // words per line
    localparam int num_lines  = 16;  // direct-mapped sets

    // address field widths, msb to lsb: tag | index | offset | byte
    localparam int offset_w = 2;
    localparam int index_w  = 4;
    localparam int byte_w   = 2;
    localparam int tag_w    = addr_w - index_w - offset_w - byte_w;  // 24

    // one 32-bit address, seen either as the flat bus word or split
    // into the fields the line store and the memory port index with
    typedef union packed {
        logic [addr_w-1:0] word;  // as carried on cpu_adr / mem_adr
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;    // word within the line
            logic [byte_w-1:0]   byte_off;  // ignored, no sel support
        } f;
    } cache_addr_u;

endpackage

// ==== logic/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // miss handling states of cache_control
    typedef enum logic [2:0] {
        s_idle      = 3'h0,  // hits served here
        s_back      = 3'h1,  // start write-back of dirty victim
        s_back_wait = 3'h2,
        s_fill      = 3'h3,  // start line fetch
        s_fill_wait = 3'h4,
        s_respond   = 3'h5   // replay request as a hit
    } ctrl_state_t;

    // direction of a whole-line transfer on the memory bus
    typedef enum logic {
        xfer_back  = 1'b0,  // cache -> memory
        xfer_fetch = 1'b1   // memory -> cache
    } xfer_dir_t;

endpackage

// ==== logic/cache_control.sv ====
`timescale 1ns/1ps

module cache_control
    import cache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_cyc,
    input  logic      cpu_stb,
    input  logic      cpu_we,
    input  logic      hit,
    input  logic      dirty,
    input  logic      fill_valid,  // fetched word present from memory port
    input  logic      xfer_done,
    output logic      cpu_ack,
    output logic      cpu_wr_en,
    output logic      fill_we,
    output logic      xfer_start,
    output xfer_dir_t xfer_dir
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        req;       // classic request pending on the cpu bus
    logic        stall;     // miss in progress, hold off the ack
    logic        ack_next;

    assign req = cpu_cyc & cpu_stb;

    // only idle and respond may answer the cpu
    assign stall = (state != s_idle) && (state != s_respond);

    // one-cycle ack, never back to back for the same request
    assign ack_next = req & hit & ~cpu_ack & ~stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= s_idle;
            cpu_ack <= 1'b0;
        end else begin
            state   <= state_next;
            cpu_ack <= ack_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                // victim dirty bit picks write-back before fill
                if (req && !cpu_ack && !hit) begin
                    state_next = dirty ? s_back : s_fill;
                end
            end
            s_back: begin
                state_next = s_back_wait;
            end
            s_back_wait: begin
                if (xfer_done) begin
                    state_next = s_fill;
                end
            end
            s_fill: begin
                state_next = s_fill_wait;
            end
            s_fill_wait: begin
                if (xfer_done) begin
                    state_next = s_respond;
                end
            end
            s_respond: begin
                state_next = s_idle;  // ack (if still requested) raised on the way out
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // transfer kicks off for one cycle in back and fill
    assign xfer_start = (state == s_back) || (state == s_fill);
    assign xfer_dir   = (state == s_back) ? xfer_back : xfer_fetch;

    // store writes
    assign fill_we   = fill_valid & (state == s_fill_wait);  // only our own fetch
    assign cpu_wr_en = cpu_ack & req & cpu_we;               // write lands at the ack edge

endmodule

// ==== logic/cache_line_store.sv ====
`timescale 1ns/1ps

module cache_line_store
    import cache_geom_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  cache_addr_u         cpu_adr,
    input  logic [data_w-1:0]   cpu_dat_w,
    input  logic                cpu_wr_en,
    input  logic                fill_we,
    input  logic [offset_w-1:0] fill_idx,
    input  logic [data_w-1:0]   fill_word,
    input  logic [offset_w-1:0] drain_word_idx,
    output logic                hit,
    output logic                dirty,
    output logic [tag_w-1:0]    victim_tag,
    output logic [data_w-1:0]   cpu_dat_r,
    output logic [data_w-1:0]   line_rd_data
);

    localparam logic [offset_w-1:0] last_word = offset_w'(line_words - 1);

    logic [tag_w-1:0]  tag_mem  [num_lines];
    logic [data_w-1:0] data_mem [num_lines * line_words];  // word addr = {index, offset}

    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    logic [index_w-1:0]  idx;
    logic                fill_last;  // final word of a line fill

    assign idx       = cpu_adr.f.index;
    assign fill_last = fill_we && (fill_idx == last_word);

    // lookup
    assign victim_tag = tag_mem[idx];
    assign hit        = valid_bits[idx] && (victim_tag == cpu_adr.f.tag);
    assign dirty      = valid_bits[idx] && dirty_bits[idx];

    // cpu word read, valid alongside the ack
    assign cpu_dat_r = data_mem[{idx, cpu_adr.f.offset}];

    // drain side for write-back, indexed by the memory port beat
    assign line_rd_data = data_mem[{idx, drain_word_idx}];

    // data and tags
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[{idx, fill_idx}] <= fill_word;
        end else if (cpu_wr_en) begin
            data_mem[{idx, cpu_adr.f.offset}] <= cpu_dat_w;  // full word, sel ignored
        end
        if (fill_last) begin
            tag_mem[idx] <= cpu_adr.f.tag;  // tag goes in with the last word
        end
    end

    // line status bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (fill_last) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b0;  // fresh copy of memory
            end else if (cpu_wr_en) begin
                dirty_bits[idx] <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/mem_line_port.sv ====
`timescale 1ns/1ps

module mem_line_port
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                xfer_start,
    input  xfer_dir_t           xfer_dir,
    input  cache_addr_u         cpu_adr,
    input  logic [tag_w-1:0]    victim_tag,
    input  logic [data_w-1:0]   line_rd_data,
    output logic [offset_w-1:0] drain_word_idx,
    output logic [offset_w-1:0] fill_idx,
    output logic [data_w-1:0]   fill_word,
    output logic                fill_valid,
    output logic                xfer_done,
    // memory side wishbone classic master
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we,
    output logic [addr_w-1:0]   mem_adr,
    output logic [data_w-1:0]   mem_dat_w,
    input  logic [data_w-1:0]   mem_dat_r,
    input  logic                mem_ack
);

    localparam logic [offset_w-1:0] last_beat = offset_w'(line_words - 1);

    logic                active;  // line transfer in flight, cyc held across beats
    xfer_dir_t           dir_q;
    logic [offset_w-1:0] beat;
    cache_addr_u         beat_adr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            dir_q     <= xfer_fetch;
            beat      <= '0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            if (xfer_start && !active) begin
                active <= 1'b1;
                dir_q  <= xfer_dir;
                beat   <= '0;
            end else if (active && mem_ack) begin
                beat <= beat + 1'b1;
                if (beat == last_beat) begin
                    active    <= 1'b0;
                    xfer_done <= 1'b1;  // cycle after the fourth ack
                end
            end
        end
    end

    // line base from victim tag on write-back, request tag on fetch
    always_comb begin
        beat_adr.f.tag      = (dir_q == xfer_back) ? victim_tag : cpu_adr.f.tag;
        beat_adr.f.index    = cpu_adr.f.index;
        beat_adr.f.offset   = beat;
        beat_adr.f.byte_off = '0;
    end

    // bus side, each beat held until its ack
    assign mem_cyc   = active;
    assign mem_stb   = active;
    assign mem_we    = active && (dir_q == xfer_back);
    assign mem_adr   = beat_adr.word;
    assign mem_dat_w = line_rd_data;

    // store side
    assign drain_word_idx = beat;
    assign fill_idx       = beat;
    assign fill_word      = mem_dat_r;
    assign fill_valid     = active && mem_ack && (dir_q == xfer_fetch);

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // cpu side, cache is the slave
    input  logic              cpu_cyc,
    input  logic              cpu_stb,
    input  logic              cpu_we,
    input  logic [addr_w-1:0] cpu_adr,
    input  logic [data_w-1:0] cpu_dat_w,
    output logic [data_w-1:0] cpu_dat_r,
    output logic              cpu_ack,
    // memory side, cache is the master
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_adr,
    output logic [data_w-1:0] mem_dat_w,
    input  logic [data_w-1:0] mem_dat_r,
    input  logic              mem_ack
);

    cache_addr_u         req_adr;  // split view of cpu_adr
    logic                hit;
    logic                dirty;
    logic                cpu_wr_en;
    logic                fill_we;
    logic                fill_valid;
    logic [offset_w-1:0] fill_idx;
    logic [data_w-1:0]   fill_word;
    logic [offset_w-1:0] drain_word_idx;
    logic [tag_w-1:0]    victim_tag;
    logic [data_w-1:0]   line_rd_data;
    logic                xfer_start;
    xfer_dir_t           xfer_dir;
    logic                xfer_done;

    assign req_adr = cpu_adr;

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .cpu_cyc    (cpu_cyc),
        .cpu_stb    (cpu_stb),
        .cpu_we     (cpu_we),
        .hit        (hit),
        .dirty      (dirty),
        .fill_valid (fill_valid),
        .xfer_done  (xfer_done),
        .cpu_ack    (cpu_ack),
        .cpu_wr_en  (cpu_wr_en),
        .fill_we    (fill_we),
        .xfer_start (xfer_start),
        .xfer_dir   (xfer_dir)
    );

    cache_line_store u_store (
        .clk            (clk),
        .rst            (rst),
        .cpu_adr        (req_adr),
        .cpu_dat_w      (cpu_dat_w),
        .cpu_wr_en      (cpu_wr_en),
        .fill_we        (fill_we),
        .fill_idx       (fill_idx),
        .fill_word      (fill_word),
        .drain_word_idx (drain_word_idx),
        .hit            (hit),
        .dirty          (dirty),
        .victim_tag     (victim_tag),
        .cpu_dat_r      (cpu_dat_r),
        .line_rd_data   (line_rd_data)
    );

    mem_line_port u_mem_port (
        .clk            (clk),
        .rst            (rst),
        .xfer_start     (xfer_start),
        .xfer_dir       (xfer_dir),
        .cpu_adr        (req_adr),
        .victim_tag     (victim_tag),
        .line_rd_data   (line_rd_data),
        .drain_word_idx (drain_word_idx),
        .fill_idx       (fill_idx),
        .fill_word      (fill_word),
        .fill_valid     (fill_valid),
        .xfer_done      (xfer_done),
        .mem_cyc        (mem_cyc),
        .mem_stb        (mem_stb),
        .mem_we         (mem_we),
        .mem_adr        (mem_adr),
        .mem_dat_w      (mem_dat_w),
        .mem_dat_r      (mem_dat_r),
        .mem_ack        (mem_ack)
    );

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import cache_geom_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic              ack,
    input  logic [1:0]        ack_delay,  // wait states before each ack
    output logic [31:0]       rd_count,
    output logic [31:0]       wr_count
);

    localparam int mem_words = 1024;  // 4 KiB, enough for tags 0 to 15

    logic [data_w-1:0] mem [mem_words];
    logic [1:0]        wait_cnt;
    logic [9:0]        word_idx;

    assign word_idx = adr[11:2];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack      <= 1'b0;
            wait_cnt <= '0;
            dat_r    <= '0;
            rd_count <= '0;
            wr_count <= '0;
        end else begin
            ack <= 1'b0;  // single-cycle ack
            if (cyc && stb && !ack) begin
                if (wait_cnt < ack_delay) begin
                    wait_cnt <= wait_cnt + 1'b1;
                end else begin
                    wait_cnt <= '0;
                    ack      <= 1'b1;
                    if (we) begin
                        mem[word_idx] <= dat_w;
                        wr_count      <= wr_count + 1;
                    end else begin
                        dat_r    <= mem[word_idx];  // valid together with ack
                        rd_count <= rd_count + 1;
                    end
                end
            end
        end
    end

endmodule

// ==== verification/cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties
    import cache_geom_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              cpu_cyc,
    input logic              cpu_stb,
    input logic              cpu_we,
    input logic [addr_w-1:0] cpu_adr,
    input logic [data_w-1:0] cpu_dat_w,
    input logic              cpu_ack,
    input logic              mem_cyc,
    input logic              mem_stb,
    input logic              mem_we,
    input logic [addr_w-1:0] mem_adr,
    input logic [data_w-1:0] mem_dat_w,
    input logic              mem_ack
);

    int unsigned prop_errors = 0;  // violation count, read by the testbench

    // strobe only inside a bus cycle
    cpu_stb_cyc: assert property (@(posedge clk) disable iff (rst) cpu_stb |-> cpu_cyc)
        else begin
            $error("cpu_stb high without cpu_cyc");
            prop_errors++;
        end
    mem_stb_cyc: assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc)
        else begin
            $error("mem_stb high without mem_cyc");
            prop_errors++;
        end

    // acks last exactly one cycle
    cpu_ack_once: assert property (@(posedge clk) disable iff (rst) cpu_ack |=> !cpu_ack)
        else begin
            $error("cpu_ack held longer than one cycle");
            prop_errors++;
        end
    mem_ack_once: assert property (@(posedge clk) disable iff (rst) mem_ack |=> !mem_ack)
        else begin
            $error("mem_ack held longer than one cycle");
            prop_errors++;
        end

    // classic handshake, request fields frozen until the ack
    cpu_hold: assert property (@(posedge clk) disable iff (rst)
        (cpu_stb && !cpu_ack) |=> cpu_stb && $stable({cpu_we, cpu_adr, cpu_dat_w}))
        else begin
            $error("cpu request changed before ack");
            prop_errors++;
        end
    mem_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_stb && !mem_ack) |=> mem_stb && $stable({mem_we, mem_adr, mem_dat_w}))
        else begin
            $error("memory beat changed before ack");
            prop_errors++;
        end

endmodule

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
    import cache_geom_pkg::*;
();

    localparam int mem_words = 1024;
    localparam int n_random  = 200;
    localparam int n_trans   = 5 + n_random;  // directed accesses plus random ones

    logic        clk;
    logic        rst;
    logic        cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    logic [31:0] cpu_adr, cpu_dat_w, cpu_dat_r;
    logic        mem_cyc, mem_stb, mem_we, mem_ack;
    logic [31:0] mem_adr, mem_dat_w, mem_dat_r;
    logic [1:0]  ack_delay;
    logic [31:0] rd_count, wr_count;

    logic [31:0] ref_mem [mem_words];  // what the cpu must see
    logic [31:0] rng_state = 32'd28035;
    logic [31:0] rdata;
    logic [7:0]  we_log;   // mem_we per memory ack, oldest beat in the msb
    logic [31:0] beat_adr_log [$];  // mem_adr per memory ack, in bus order
    int          cycles, mem_cycles, rd0, wr0;

    cache_top u_dut (.*);

    mem_model u_mem (
        .clk(clk), .rst(rst), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we), .adr(mem_adr),
        .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack), .ack_delay(ack_delay),
        .rd_count(rd_count), .wr_count(wr_count)
    );

    bind cache_top cache_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (200 * n_trans) @(posedge clk);
        $display("watchdog expired, a bus transaction never finished");
        stop_on_error();
    end

    initial begin
        wait (u_dut.u_props.prop_errors != 0);
        $display("a bus protocol property failed");
        stop_on_error();
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
            stop_on_error();
        end
    endtask

    // one classic cycle, held past the ack edge before release
    task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata);
        @(negedge clk);
        {cpu_cyc, cpu_stb, cpu_we} = {2'b11, we};
        cpu_adr      = adr;
        cpu_dat_w    = wdata;
        cycles       = 0;
        mem_cycles   = 0;
        we_log       = '0;
        beat_adr_log = {};
        do begin
            @(negedge clk);
            cycles++;
            if (mem_cyc) mem_cycles++;
            if (mem_ack) begin
                we_log = {we_log[6:0], mem_we};
                beat_adr_log.push_back(mem_adr);
            end
        end while (!cpu_ack);
        rdata = cpu_dat_r;
        @(negedge clk);
        {cpu_cyc, cpu_stb, cpu_we} = 3'b000;
    endtask

    task automatic reset_outputs_idle();
        check_value("reset_outputs_idle", 32'd0, {cpu_ack, mem_cyc, mem_stb});
    endtask

    task automatic cold_read_miss();
        {rd0, wr0} = {rd_count, wr_count};
        cpu_access(1'b0, 32'h40, 32'd0);
        check_value("cold_read_miss data", ref_mem[16], rdata);
        check_value("cold_read_miss reads", 32'd4, rd_count - rd0);
        check_value("cold_read_miss writes", 32'd0, wr_count - wr0);
    endtask

    task automatic repeated_read_hit();
        cpu_access(1'b0, 32'h44, 32'd0);
        check_value("repeated_read_hit data", ref_mem[17], rdata);
        check_value("repeated_read_hit latency", 32'd1, cycles);
        check_value("repeated_read_hit mem_cyc", 32'd0, mem_cycles);
    endtask

    task automatic write_then_read_hit();
        {rd0, wr0} = {rd_count, wr_count};
        ref_mem[18] = 32'hc0de_5a17;
        cpu_access(1'b1, 32'h48, ref_mem[18]);
        check_value("write_then_read_hit write latency", 32'd1, cycles);
        cpu_access(1'b0, 32'h48, 32'd0);
        check_value("write_then_read_hit data", ref_mem[18], rdata);
        check_value("write_then_read_hit traffic", 32'd0, (rd_count - rd0) + (wr_count - wr0));
    endtask

    // same index 4, tag 1, evicts the dirty line of the previous test
    task automatic dirty_victim_writeback();
        {rd0, wr0} = {rd_count, wr_count};
        ack_delay = 2'd2;
        cpu_access(1'b0, 32'h148, 32'd0);
        ack_delay = 2'd0;
        check_value("dirty_victim_writeback order", 32'h0f0, we_log);
        check_value("dirty_victim_writeback writes", 32'd4, wr_count - wr0);
        check_value("dirty_victim_writeback reads", 32'd4, rd_count - rd0);
        // victim line 0x040 goes out first, then line 0x140 comes in, words 0 to 3 each
        for (int k = 0; k < 8; k++) begin
            check_value("dirty_victim_writeback address",
                        (k < 4 ? 32'h040 : 32'h140) + 32'(4 * (k % 4)), beat_adr_log[k]);
        end
        check_value("dirty_victim_writeback memory", ref_mem[18], u_mem.mem[18]);
        check_value("dirty_victim_writeback data", ref_mem[82], rdata);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] wdata;
        for (int i = 0; i < n_random; i++) begin
            rng_state = xorshift(rng_state);
            r         = rng_state;
            rng_state = xorshift(rng_state);
            wdata     = rng_state;
            adr       = {22'd0, r[9:2], 2'b00};  // first 1 KiB, four tags per index
            ack_delay = r[13:12];
            cpu_access(r[16], adr, wdata);
            if (r[16]) ref_mem[adr[11:2]] = wdata;
            else check_value("random_traffic", ref_mem[adr[11:2]], rdata);
        end
    endtask

    initial begin
        rst       = 1'b1;
        {cpu_cyc, cpu_stb, cpu_we} = 3'b000;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        ack_delay = 2'd0;
        for (int i = 0; i < mem_words; i++) begin
            rng_state   = xorshift(rng_state);
            ref_mem[i]  = rng_state ^ (32'(i) * 32'h9e37_79b9);
            u_mem.mem[i] = ref_mem[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_outputs_idle();
        cold_read_miss();
        repeated_read_hit();
        write_then_read_hit();
        dirty_victim_writeback();
        random_traffic();
        if (u_dut.u_props.prop_errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("bus protocol properties failed %0d times", u_dut.u_props.prop_errors);
            stop_on_error();
        end
    end

endmodule

// ==== all.f ====
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_control.sv
logic/cache_line_store.sv
logic/mem_line_port.sv
logic/cache_top.sv
verification/mem_model.sv
verification/cache_properties.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: wb_cache

sources:
  - files:
      - logic/cache_geom_pkg.sv
      - logic/cache_ctrl_pkg.sv
      - logic/cache_control.sv
      - logic/cache_line_store.sv
      - logic/mem_line_port.sv
      - logic/cache_top.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/cache_properties.sv
      - verification/cache_tb.sv
